/* Bender.yml */
package:
  name: rv_decoder

sources:
  - hdl/rv_decoder_pkg.sv
  - hdl/opcode_ctrl_decoder.sv
  - hdl/alu_op_decoder.sv
  - hdl/source_reg_filter.sv
  - hdl/rv_decoder.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/rv_decoder_assertions.sv
      - verif/tb_rv_decoder.sv

/* hdl/alu_op_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_op_decoder
    import rv_decoder_pkg::*;
(
    input  op_class_t  op_class_i,
    input  logic [2:0] func3_i,
    input  logic [6:0] func7_i,
    output alu_op_t    alu_op_o,
    output logic       is_mul_o,
    output logic [2:0] exe_stages_o,
    output logic       func_legal_o
);

    logic is_alu_class;
    logic is_shift;

    assign is_alu_class = (op_class_i == CLASS_ALU_IMM) || (op_class_i == CLASS_ALU_REG);
    assign is_shift     = (func3_i == F3_SLL) || (func3_i == F3_SRL_SRA);

    always_comb begin
        alu_op_o     = ADD;
        is_mul_o     = 1'b0;
        exe_stages_o = EXE_STAGES_ALU;
        func_legal_o = 1'b1;

        if (is_alu_class) begin
            // operation implied by func3 with a normal func7
            case (func3_i)
                F3_ADD_SUB: alu_op_o = ADD;
                F3_SLL:     alu_op_o = SLL;
                F3_SLT:     alu_op_o = SLT;
                F3_SLTU:    alu_op_o = SLTU;
                F3_XOR:     alu_op_o = XOR;
                F3_SRL_SRA: alu_op_o = SRL;
                F3_OR:      alu_op_o = OR;
                default:    alu_op_o = AND;
            endcase

            if (op_class_i == CLASS_ALU_REG) begin
                if (func3_i == F3_ADD_SUB && func7_i == F7_MUL) begin
                    is_mul_o     = 1'b1;
                    exe_stages_o = EXE_STAGES_MUL;
                end else if (func3_i == F3_ADD_SUB && func7_i == F7_ALU_MODIFIED) begin
                    alu_op_o = SUB;
                end else if (func3_i == F3_SRL_SRA && func7_i == F7_ALU_MODIFIED) begin
                    alu_op_o = SRA;
                end else if (func7_i != F7_ALU_NORMAL) begin
                    func_legal_o = 1'b0;
                end
            end else if (is_shift) begin
                // upper bits of an immediate form are immediate except for shifts
                if (func3_i == F3_SRL_SRA && func7_i == F7_ALU_MODIFIED) begin
                    alu_op_o = SRA;
                end else if (func7_i != F7_ALU_NORMAL) begin
                    func_legal_o = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/opcode_ctrl_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module opcode_ctrl_decoder
    import rv_decoder_pkg::*;
(
    input  instr_t       instr_i,
    output op_class_t    op_class_o,
    output ctrl_fields_t ctrl_o
);

    always_comb begin
        op_class_o          = CLASS_OTHER;
        ctrl_o.write_enable = 1'b1;
        ctrl_o.rs1_or_pc    = RS1;
        ctrl_o.rs2_or_imm   = IMM;
        ctrl_o.wb_origin    = ALU;
        ctrl_o.store_to_mem = 1'b0;
        ctrl_o.jump_kind    = BNONE;

        case (instr_i.opcode)
            OP_ALU_I: begin
                op_class_o = CLASS_ALU_IMM;
            end
            OP_ALU: begin
                op_class_o        = CLASS_ALU_REG;
                ctrl_o.rs2_or_imm = RS2;
            end
            OP_LUI: begin
                // rs1 is dropped to x0 later, so this is 0 + imm
                ctrl_o.rs1_or_pc = RS1;
            end
            OP_AUIPC: begin
                ctrl_o.rs1_or_pc = PC;
            end
            OP_LW: begin
                ctrl_o.wb_origin = MEM;
            end
            OP_SW: begin
                ctrl_o.write_enable = 1'b0;
                ctrl_o.store_to_mem = 1'b1;
            end
            OP_BRANCH: begin
                // target is pc + imm while the comparison uses rs1 and rs2
                ctrl_o.write_enable = 1'b0;
                ctrl_o.rs1_or_pc    = PC;
                case (instr_i.func3)
                    F3_BEQ:  ctrl_o.jump_kind = BEQ;
                    F3_BNE:  ctrl_o.jump_kind = BNE;
                    F3_BLT:  ctrl_o.jump_kind = BLT;
                    F3_BGE:  ctrl_o.jump_kind = BGE;
                    F3_BLTU: ctrl_o.jump_kind = BLTU;
                    F3_BGEU: ctrl_o.jump_kind = BGEU;
                    // never taken and never writes, so it behaves as a NOP
                    default: ctrl_o.jump_kind = BNONE;
                endcase
            end
            OP_JAL: begin
                ctrl_o.rs1_or_pc = PC;
                ctrl_o.wb_origin = PC_4;
                ctrl_o.jump_kind = JUMP;
            end
            default: begin
                op_class_o = CLASS_ILLEGAL;
                ctrl_o     = CTRL_NOP;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decoder
    import rv_decoder_pkg::*;
(
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           valid_i,
    input  word_t          pc_i,
    input  instr_t         instr_i,
    output logic           valid_o,
    output decoded_instr_t decoded_o
);

    op_class_t      op_class;
    ctrl_fields_t   ctrl_raw;
    ctrl_fields_t   ctrl_final;
    alu_op_t        alu_op_raw;
    alu_op_t        alu_op_final;
    logic           is_mul;
    logic [2:0]     exe_stages;
    logic           func_legal;
    reg_addr_t      addr_rs1;
    reg_addr_t      addr_rs2;
    reg_addr_t      addr_rd;
    decoded_instr_t decoded_d;

    opcode_ctrl_decoder i_opcode_ctrl_decoder (
        .instr_i    (instr_i),
        .op_class_o (op_class),
        .ctrl_o     (ctrl_raw)
    );

    alu_op_decoder i_alu_op_decoder (
        .op_class_i   (op_class),
        .func3_i      (instr_i.func3),
        .func7_i      (instr_i.func7),
        .alu_op_o     (alu_op_raw),
        .is_mul_o     (is_mul),
        .exe_stages_o (exe_stages),
        .func_legal_o (func_legal)
    );

    source_reg_filter i_source_reg_filter (
        .instr_i      (instr_i),
        .op_class_i   (op_class),
        .func_legal_i (func_legal),
        .ctrl_i       (ctrl_raw),
        .alu_op_i     (alu_op_raw),
        .ctrl_o       (ctrl_final),
        .alu_op_o     (alu_op_final),
        .addr_rs1_o   (addr_rs1),
        .addr_rs2_o   (addr_rs2),
        .addr_rd_o    (addr_rd)
    );

    always_comb begin
        decoded_d.pc         = pc_i;
        decoded_d.instr      = instr_i;
        decoded_d.addr_rs1   = addr_rs1;
        decoded_d.addr_rs2   = addr_rs2;
        decoded_d.addr_rd    = addr_rd;
        decoded_d.alu_op     = alu_op_final;
        decoded_d.is_mul     = is_mul;
        decoded_d.exe_stages = exe_stages;
        decoded_d.ctrl       = ctrl_final;
    end

    // bundle only updates on a strobe and holds otherwise
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o   <= 1'b0;
            decoded_o <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                decoded_o <= decoded_d;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_decoder_pkg.sv */
`default_nettype none

package rv_decoder_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // number of execute stages a decoded instruction occupies
    localparam logic [2:0] EXE_STAGES_ALU = 3'd1;
    localparam logic [2:0] EXE_STAGES_MUL = 3'd4;

    // branch func3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // alu func3 codes where MUL shares F3_ADD_SUB
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_ALU_NORMAL   = 7'b0000000;
    localparam logic [6:0] F7_ALU_MODIFIED = 7'b0100000;
    localparam logic [6:0] F7_MUL          = 7'b0000001;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // fields laid out as in the R-type format
    typedef struct packed {
        logic [6:0] func7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] func3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } instr_t;

    typedef enum logic [6:0] {
        OP_ALU_I  = 7'b0010011,
        OP_ALU    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_LW     = 7'b0000011,
        OP_SW     = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        CLASS_ALU_IMM,
        CLASS_ALU_REG,
        CLASS_OTHER,
        CLASS_ILLEGAL
    } op_class_t;

    typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} alu_op_t;

    typedef enum logic {RS1, PC} src_a_t;
    typedef enum logic {RS2, IMM} src_b_t;

    typedef enum logic [1:0] {ALU, MEM, PC_4} wb_origin_t;

    typedef enum logic [2:0] {BNONE, BEQ, BNE, BLT, BGE, BLTU, BGEU, JUMP} jump_kind_t;

    typedef struct packed {
        logic       write_enable;
        src_a_t     rs1_or_pc;
        src_b_t     rs2_or_imm;
        wb_origin_t wb_origin;
        logic       store_to_mem;
        jump_kind_t jump_kind;
    } ctrl_fields_t;

    // x0 + x0 without write for every illegal encoding
    localparam ctrl_fields_t CTRL_NOP = '{
        write_enable: 1'b0,
        rs1_or_pc:    RS1,
        rs2_or_imm:   RS2,
        wb_origin:    ALU,
        store_to_mem: 1'b0,
        jump_kind:    BNONE
    };

    typedef struct packed {
        word_t        pc;
        instr_t       instr;
        reg_addr_t    addr_rs1;
        reg_addr_t    addr_rs2;
        reg_addr_t    addr_rd;
        alu_op_t      alu_op;
        logic         is_mul;
        logic [2:0]   exe_stages;
        ctrl_fields_t ctrl;
    } decoded_instr_t;

endpackage

`default_nettype wire

/* hdl/source_reg_filter.sv */
`timescale 1ns/100ps
`default_nettype none

module source_reg_filter
    import rv_decoder_pkg::*;
(
    input  instr_t       instr_i,
    input  op_class_t    op_class_i,
    input  logic         func_legal_i,
    input  ctrl_fields_t ctrl_i,
    input  alu_op_t      alu_op_i,
    output ctrl_fields_t ctrl_o,
    output alu_op_t      alu_op_o,
    output reg_addr_t    addr_rs1_o,
    output reg_addr_t    addr_rs2_o,
    output reg_addr_t    addr_rd_o
);

    logic make_nop;
    logic cond_branch;
    logic is_lui_like;

    assign make_nop    = (op_class_i == CLASS_ILLEGAL) || !func_legal_i;
    assign cond_branch = (ctrl_i.jump_kind != BNONE) && (ctrl_i.jump_kind != JUMP);
    assign is_lui_like = (op_class_i == CLASS_OTHER) && (ctrl_i.rs1_or_pc == RS1) &&
                         ctrl_i.write_enable && (ctrl_i.wb_origin == ALU) &&
                         !ctrl_i.store_to_mem && (ctrl_i.jump_kind == BNONE);

    always_comb begin
        ctrl_o     = ctrl_i;
        alu_op_o   = alu_op_i;
        addr_rs1_o = instr_i.rs1;
        addr_rs2_o = instr_i.rs2;
        addr_rd_o  = instr_i.rd;

        if (make_nop) begin
            ctrl_o     = CTRL_NOP;
            alu_op_o   = ADD;
            addr_rs1_o = '0;
            addr_rs2_o = '0;
            addr_rd_o  = '0;
        end else begin
            // unread sources go to x0 so hazard logic sees no false dependency
            if ((ctrl_i.rs1_or_pc == PC && !cond_branch) || is_lui_like) begin
                addr_rs1_o = '0;
            end
            if (ctrl_i.rs2_or_imm == IMM && !ctrl_i.store_to_mem && !cond_branch) begin
                addr_rs2_o = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* rv_decoder.f */
hdl/rv_decoder_pkg.sv
hdl/opcode_ctrl_decoder.sv
hdl/alu_op_decoder.sv
hdl/source_reg_filter.sv
hdl/rv_decoder.sv
verif/tb_clock_gen.sv
verif/rv_decoder_assertions.sv
verif/tb_rv_decoder.sv

/* verif/rv_decoder_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decoder_assertions
    import rv_decoder_pkg::*;
(
    input logic           clk_i,
    input logic           reset_i,
    input logic           valid_i,
    input logic           valid_o,
    input decoded_instr_t decoded_o
);

    int unsigned fail_count = 0;

    // valid_o is valid_i delayed by one cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
        !$past(reset_i) |-> valid_o == $past(valid_i))
    else begin
        $error("valid_o does not follow valid_i one cycle later");
        fail_count++;
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        decoded_o.is_mul |-> decoded_o.exe_stages == EXE_STAGES_MUL)
    else begin
        $error("multiply decoded without the multiply stage count");
        fail_count++;
    end

    // stores and branches carry immediate bits in the rd field
    assert property (@(posedge clk_i) disable iff (reset_i)
        !decoded_o.ctrl.write_enable && !decoded_o.ctrl.store_to_mem &&
        decoded_o.instr.opcode != OP_BRANCH |-> decoded_o.addr_rd == '0)
    else begin
        $error("instruction without write has a nonzero rd address");
        fail_count++;
    end

endmodule

bind rv_decoder rv_decoder_assertions i_rv_decoder_assertions (.*);

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // reset is seen high on the first three rising edges
    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* verif/tb_rv_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_decoder
    import rv_decoder_pkg::*;
();

    typedef struct packed {
        instr_t       instr;
        alu_op_t      alu_op;
        logic         is_mul;
        ctrl_fields_t ctrl;
        logic [2:0]   keep;
    } vector_t;

    logic           clk;
    logic           reset;
    logic           valid_in;
    word_t          pc;
    instr_t         instr;
    logic           valid_out;
    decoded_instr_t decoded;

    vector_t     vectors[$];
    int unsigned cycle_count = 0;
    int unsigned cycle_limit;
    int unsigned num_random  = 40;
    alu_op_t     f3_ops [8]    = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    jump_kind_t  br_kinds [8]  = '{BEQ, BNE, BNONE, BNONE, BLT, BGE, BLTU, BGEU};
    opcode_t     legal_ops [8] = '{OP_ALU_I, OP_ALU, OP_LUI, OP_AUIPC, OP_LW, OP_SW,
                                   OP_BRANCH, OP_JAL};

    tb_clock_gen i_tb_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    rv_decoder i_rv_decoder (
        .clk_i     (clk),
        .reset_i   (reset),
        .valid_i   (valid_in),
        .pc_i      (pc),
        .instr_i   (instr),
        .valid_o   (valid_out),
        .decoded_o (decoded)
    );

    task automatic compare(string name, logic [127:0] actual, logic [127:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_decoded(decoded_instr_t exp);
        compare("decoded_o.pc", decoded.pc, exp.pc);
        compare("decoded_o.instr", decoded.instr, exp.instr);
        compare("decoded_o.addr_rs1", decoded.addr_rs1, exp.addr_rs1);
        compare("decoded_o.addr_rs2", decoded.addr_rs2, exp.addr_rs2);
        compare("decoded_o.addr_rd", decoded.addr_rd, exp.addr_rd);
        compare("decoded_o.alu_op", decoded.alu_op, exp.alu_op);
        compare("decoded_o.is_mul", decoded.is_mul, exp.is_mul);
        compare("decoded_o.exe_stages", decoded.exe_stages, exp.exe_stages);
        compare("decoded_o.ctrl", decoded.ctrl, exp.ctrl);
    endtask

    function automatic ctrl_fields_t make_ctrl(logic we, src_a_t a, src_b_t b, wb_origin_t wb,
                                               logic st, jump_kind_t jk);
        return '{we, a, b, wb, st, jk};
    endfunction

    // register fields are fixed so each one is recognisable in the output
    function automatic instr_t encode(logic [6:0] f7, logic [2:0] f3, logic [6:0] op);
        return '{f7, 5'd20, 5'd9, f3, 5'd7, op};
    endfunction

    function automatic void add_row(instr_t ins, alu_op_t op, logic mul, ctrl_fields_t c,
                                    logic [2:0] keep);
        vectors.push_back('{ins, op, mul, c, keep});
    endfunction

    // keep bits say which of rs1, rs2 and rd pass through unchanged
    function automatic decoded_instr_t expected_from_row(word_t pc_val, vector_t v);
        decoded_instr_t d;
        d.pc         = pc_val;
        d.instr      = v.instr;
        d.addr_rs1   = v.keep[2] ? v.instr.rs1 : '0;
        d.addr_rs2   = v.keep[1] ? v.instr.rs2 : '0;
        d.addr_rd    = v.keep[0] ? v.instr.rd : '0;
        d.alu_op     = v.alu_op;
        d.is_mul     = v.is_mul;
        d.exe_stages = v.is_mul ? EXE_STAGES_MUL : EXE_STAGES_ALU;
        d.ctrl       = v.ctrl;
        return d;
    endfunction

    function automatic void build_table();
        ctrl_fields_t reg_ctrl = make_ctrl(1'b1, RS1, RS2, ALU, 1'b0, BNONE);
        ctrl_fields_t imm_ctrl = make_ctrl(1'b1, RS1, IMM, ALU, 1'b0, BNONE);
        ctrl_fields_t nop_ctrl = make_ctrl(1'b0, RS1, RS2, ALU, 1'b0, BNONE);
        for (int f = 0; f < 8; f++) begin
            add_row(encode(F7_ALU_NORMAL, 3'(f), OP_ALU), f3_ops[f], 1'b0, reg_ctrl, 3'b111);
            add_row(encode(F7_ALU_NORMAL, 3'(f), OP_ALU_I), f3_ops[f], 1'b0, imm_ctrl, 3'b101);
        end
        add_row(encode(F7_ALU_MODIFIED, F3_ADD_SUB, OP_ALU), SUB, 1'b0, reg_ctrl, 3'b111);
        add_row(encode(F7_ALU_MODIFIED, F3_SRL_SRA, OP_ALU), SRA, 1'b0, reg_ctrl, 3'b111);
        add_row(encode(F7_MUL, F3_ADD_SUB, OP_ALU), ADD, 1'b1, reg_ctrl, 3'b111);
        add_row(encode(F7_ALU_MODIFIED, F3_SRL_SRA, OP_ALU_I), SRA, 1'b0, imm_ctrl, 3'b101);
        // upper immediate bits of a non-shift are not a func7
        add_row(encode(7'h55, F3_ADD_SUB, OP_ALU_I), ADD, 1'b0, imm_ctrl, 3'b101);
        add_row(encode(7'h2a, F3_AND, OP_ALU_I), AND, 1'b0, imm_ctrl, 3'b101);
        add_row(encode(7'h13, 3'b000, OP_LUI), ADD, 1'b0, imm_ctrl, 3'b001);
        add_row(encode(7'h13, 3'b000, OP_AUIPC), ADD, 1'b0,
                make_ctrl(1'b1, PC, IMM, ALU, 1'b0, BNONE), 3'b001);
        add_row(encode(7'h00, 3'b010, OP_LW), ADD, 1'b0,
                make_ctrl(1'b1, RS1, IMM, MEM, 1'b0, BNONE), 3'b101);
        add_row(encode(7'h00, 3'b010, OP_SW), ADD, 1'b0,
                make_ctrl(1'b0, RS1, IMM, ALU, 1'b1, BNONE), 3'b111);
        add_row(encode(7'h7f, 3'b000, OP_JAL), ADD, 1'b0,
                make_ctrl(1'b1, PC, IMM, PC_4, 1'b0, JUMP), 3'b001);
        // the two unused branch func3 codes fall back to BNONE
        for (int f = 0; f < 8; f++) begin
            add_row(encode(7'h40, 3'(f), OP_BRANCH), ADD, 1'b0,
                    make_ctrl(1'b0, PC, IMM, ALU, 1'b0, br_kinds[f]),
                    br_kinds[f] == BNONE ? 3'b001 : 3'b111);
        end
        add_row(encode(7'h00, 3'b000, 7'h7f), ADD, 1'b0, nop_ctrl, 3'b000);
        add_row(encode(7'h10, F3_ADD_SUB, OP_ALU), ADD, 1'b0, nop_ctrl, 3'b000);
        add_row(encode(F7_MUL, F3_SLL, OP_ALU), ADD, 1'b0, nop_ctrl, 3'b000);
        add_row(encode(F7_ALU_MODIFIED, F3_XOR, OP_ALU), ADD, 1'b0, nop_ctrl, 3'b000);
        add_row(encode(F7_ALU_MODIFIED, F3_SLL, OP_ALU_I), ADD, 1'b0, nop_ctrl, 3'b000);
        add_row(encode(F7_MUL, F3_SRL_SRA, OP_ALU_I), ADD, 1'b0, nop_ctrl, 3'b000);
    endfunction

    // reference decode for random words
    function automatic decoded_instr_t model(word_t pc_val, instr_t ins);
        decoded_instr_t d;
        logic           legal;
        logic           cond;
        logic           shift;
        d            = '0;
        d.pc         = pc_val;
        d.instr      = ins;
        d.exe_stages = EXE_STAGES_ALU;
        d.ctrl       = make_ctrl(1'b1, RS1, IMM, ALU, 1'b0, BNONE);
        d.alu_op     = (ins.opcode == OP_ALU || ins.opcode == OP_ALU_I) ? f3_ops[ins.func3] : ADD;
        legal        = 1'b1;
        shift        = ins.func3 == F3_SLL || ins.func3 == F3_SRL_SRA;
        case (ins.opcode)
            OP_ALU: begin
                d.ctrl.rs2_or_imm = RS2;
                if (ins.func7 == F7_MUL && ins.func3 == F3_ADD_SUB) begin
                    d.is_mul     = 1'b1;
                    d.exe_stages = EXE_STAGES_MUL;
                end else if (ins.func7 == F7_ALU_MODIFIED && ins.func3 == F3_ADD_SUB) begin
                    d.alu_op = SUB;
                end else if (ins.func7 == F7_ALU_MODIFIED && ins.func3 == F3_SRL_SRA) begin
                    d.alu_op = SRA;
                end else if (ins.func7 != F7_ALU_NORMAL) begin
                    legal = 1'b0;
                end
            end
            OP_ALU_I: begin
                if (shift && ins.func7 == F7_ALU_MODIFIED && ins.func3 == F3_SRL_SRA) begin
                    d.alu_op = SRA;
                end else if (shift && ins.func7 != F7_ALU_NORMAL) begin
                    legal = 1'b0;
                end
            end
            OP_LUI: ;
            OP_AUIPC: d.ctrl.rs1_or_pc = PC;
            OP_LW: d.ctrl.wb_origin = MEM;
            OP_SW: d.ctrl = make_ctrl(1'b0, RS1, IMM, ALU, 1'b1, BNONE);
            OP_BRANCH: d.ctrl = make_ctrl(1'b0, PC, IMM, ALU, 1'b0, br_kinds[ins.func3]);
            OP_JAL: d.ctrl = make_ctrl(1'b1, PC, IMM, PC_4, 1'b0, JUMP);
            default: legal = 1'b0;
        endcase
        cond = d.ctrl.jump_kind != BNONE && d.ctrl.jump_kind != JUMP;
        if (!legal) begin
            d.ctrl       = make_ctrl(1'b0, RS1, RS2, ALU, 1'b0, BNONE);
            d.alu_op     = ADD;
            d.is_mul     = 1'b0;
            d.exe_stages = EXE_STAGES_ALU;
        end else begin
            if (!((d.ctrl.rs1_or_pc == PC && !cond) || ins.opcode == OP_LUI))
                d.addr_rs1 = ins.rs1;
            if (!(d.ctrl.rs2_or_imm == IMM && !d.ctrl.store_to_mem && !cond))
                d.addr_rs2 = ins.rs2;
            d.addr_rd = ins.rd;
        end
        return d;
    endfunction

    task automatic drive(word_t pc_val, instr_t ins);
        valid_in = 1'b1;
        pc       = pc_val;
        instr    = ins;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("run stopped: no result after %0d cycles", cycle_count);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    always @(i_rv_decoder.i_rv_decoder_assertions.fail_count) begin
        if (i_rv_decoder.i_rv_decoder_assertions.fail_count != 0) begin
            $display("a concurrent assertion in the bound checker failed");
            $display("Finished with errors");
            $fatal(1, "concurrent assertion failed");
        end
    end

    initial begin
        word_t  pc_val;
        instr_t word;
        valid_in = 1'b0;
        pc       = '0;
        instr    = '0;
        void'($urandom(54428));
        build_table();
        cycle_limit = 2 * vectors.size() + num_random + 20;

        next_cycle();
        while (reset) next_cycle();
        compare("valid_o", valid_out, 1'b0);
        compare("decoded_o", decoded, '0);

        // one strobe per row and then a gap with changed inputs to check the hold
        foreach (vectors[i]) begin
            pc_val = 32'h0000_1000 + 4 * i;
            drive(pc_val, vectors[i].instr);
            next_cycle();
            valid_in = 1'b0;
            pc       = ~pc;
            instr    = ~instr;
            compare("valid_o", valid_out, 1'b1);
            check_decoded(expected_from_row(pc_val, vectors[i]));
            next_cycle();
            compare("valid_o", valid_out, 1'b0);
            check_decoded(expected_from_row(pc_val, vectors[i]));
        end

        // back to back strobes mostly with a legal opcode
        for (int k = 0; k < num_random; k++) begin
            word   = $urandom;
            pc_val = $urandom;
            if ($urandom % 10 < 8)
                word.opcode = legal_ops[$urandom % 8];
            case ($urandom % 4)
                0: word.func7 = F7_ALU_NORMAL;
                1: word.func7 = F7_ALU_MODIFIED;
                2: word.func7 = F7_MUL;
                default: ;
            endcase
            drive(pc_val, word);
            next_cycle();
            compare("valid_o", valid_out, 1'b1);
            check_decoded(model(pc_val, word));
        end
        valid_in = 1'b0;
        next_cycle();
        compare("valid_o", valid_out, 1'b0);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
